// ==== hdl/cart_bus_pkg.sv ====
`default_nettype none

// host side of the cartridge slot
package cart_bus_pkg;

    typedef logic [15:0] addr_t;    // z80 address
    typedef logic [7:0]  data_t;    // z80 data byte
    typedef logic [2:0]  msel_t;    // active low mux group select

    // one host cycle as rebuilt from the mux pins
    typedef struct packed {
        addr_t addr;
        logic  merq_n;
        logic  iorq_n;
        logic  m1_n;
        logic  rd_n;
        logic  wr_n;
        logic  sltsl_n;
    } bus_cycle_t;

    // dot sequencer, select then capture for each pin group
    typedef enum logic [2:0] {
        sel_low,
        cap_low,
        sel_high,
        cap_high,
        sel_ctrl,
        cap_ctrl,
        release_sel,    // all groups off
        idle
    } dot_phase_t;

    localparam data_t IDLE_DATA = 8'hff;    // pulled up bus

endpackage

`default_nettype wire

// ==== hdl/sdc_pkg.sv ====
`default_nettype none

// sd controller window and card reader interface
package sdc_pkg;

    typedef logic [31:0] sector_t;

    localparam logic [15:0] SDC_SDATA  = 16'h7c00;  // 512 byte transfer area
    localparam logic [15:0] SDC_ENABLE = 16'h7e00;  // bit 0 opens the window
    localparam logic [15:0] SDC_CMD    = 16'h7e01;
    localparam logic [15:0] SDC_STATUS = 16'h7e02;
    localparam logic [15:0] SDC_SADDR  = 16'h7e03;  // 4 bytes, lsb first
    localparam logic [15:0] SDC_C_SIZE = 16'h7e07;  // 3 bytes
    localparam logic [15:0] SDC_CTYPE  = 16'h7e0a;
    localparam logic [15:0] SDC_MID    = 16'h7e0b;
    localparam logic [15:0] SDC_PSN    = 16'h7e0c;  // 4 bytes
    localparam logic [15:0] SDC_END    = 16'h7eff;

    localparam logic [7:0] MAPPER_PORT = 8'h8f;

    typedef struct packed {
        logic [1:0]  card_type;     // 0 unknown, 1 sdv1, 2 sdv2, 3 sdhc
        logic [21:0] c_size;
        logic [7:0]  mid;
        logic [31:0] psn;
    } card_info_t;

    typedef struct packed {
        logic    rstart;
        logic    wstart;
        logic    init;
        sector_t sector;
    } card_req_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic crc_error;
        logic timeout_error;
    } card_stat_t;

    typedef enum logic [1:0] {konami, konami_scc, ascii16, ascii8} mapper_type_t;

endpackage

`default_nettype wire

// ==== hdl/mux_bus_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module mux_bus_sampler (
    input  wire                         clk108_w,
    input  wire                         ram_enabled_w,
    input  wire  [7:0]                  mp,
    input  wire                         rd_n,
    input  wire                         wr_n,
    input  wire                         sltsl_n,
    input  wire cart_bus_pkg::msel_t    msel_n,
    input  wire                         capture,
    output cart_bus_pkg::bus_cycle_t    cycle
);
    import cart_bus_pkg::*;

    logic [1:0] rd_sync;
    logic [1:0] wr_sync;
    logic [1:0] sltsl_sync;
    data_t      addr_lo;
    data_t      addr_hi;
    addr_t      addr_q;
    logic       merq_q;
    logic       iorq_q;
    logic       m1_q;
    logic       lo_fresh;   // low byte taken with the strobe already down
    logic       armed;      // whole frame captured inside the strobe
    logic       strobe_low;

    assign strobe_low = ~rd_sync[1] | ~wr_sync[1];

    // strobe synchronizers
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            rd_sync    <= 2'b11;
            wr_sync    <= 2'b11;
            sltsl_sync <= 2'b11;
        end else begin
            rd_sync    <= {rd_sync[0], rd_n};
            wr_sync    <= {wr_sync[0], wr_n};
            sltsl_sync <= {sltsl_sync[0], sltsl_n};
        end
    end

    always_ff @(posedge clk108_w) begin
        if (capture) begin
            case (msel_n)
                3'b110:  addr_lo <= mp;
                3'b101:  addr_hi <= mp;
                3'b011:  addr_q  <= {addr_hi, addr_lo};   // publish both bytes together
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            merq_q   <= 1'b1;
            iorq_q   <= 1'b1;
            m1_q     <= 1'b1;
            lo_fresh <= 1'b0;
            armed    <= 1'b0;
        end else begin
            if (capture && msel_n == 3'b110)
                lo_fresh <= strobe_low;
            if (capture && msel_n == 3'b011) begin
                merq_q <= mp[0];
                iorq_q <= mp[1];
                m1_q   <= mp[7];
                armed  <= lo_fresh & strobe_low;
            end
            if (!strobe_low) begin  // strobes back up, drop the cycle
                lo_fresh <= 1'b0;
                armed    <= 1'b0;
            end
        end
    end

    // strobes only count once the address belongs to them
    assign cycle = '{addr: addr_q, merq_n: merq_q, iorq_n: iorq_q, m1_n: m1_q,
                     rd_n: rd_sync[1] | ~armed, wr_n: wr_sync[1] | ~armed,
                     sltsl_n: sltsl_sync[1]};

endmodule

`default_nettype wire

// ==== hdl/cart_bus_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_bus_control (
    input  wire                             clk108_w,
    input  wire                             ram_enabled_w,
    input  wire cart_bus_pkg::bus_cycle_t   cycle,
    input  wire cart_bus_pkg::data_t        cd_in,
    input  wire                             sd_enabled,
    input  wire cart_bus_pkg::data_t        reg_rdata,
    input  wire cart_bus_pkg::data_t        buf_rdata,
    output cart_bus_pkg::msel_t             msel_n,
    output logic                            capture,
    output logic                            sdc_enable_wr,
    output logic                            sdc_sel,
    output logic                            buf_sel,
    output sdc_pkg::mapper_type_t           mapper_type,
    output cart_bus_pkg::data_t             cd_out,
    output logic                            datadir
);
    import cart_bus_pkg::*;
    import sdc_pkg::*;

    dot_phase_t phase_q;
    logic       slot_mem;
    logic       io_wr;
    logic       sdc_rd_q;
    logic       buf_rd_q;
    logic       buf_rd_q2;

    ////////////////////////////////////////////////////////////
    // dot sequencer
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase_q <= idle;
        end else begin
            phase_q <= dot_phase_t'(phase_q + 3'd1);    // idle wraps to sel_low
        end
    end

    always_comb begin
        case (phase_q)
            sel_low, cap_low:   msel_n = 3'b110;    // a0-a7
            sel_high, cap_high: msel_n = 3'b101;    // a8-a15
            sel_ctrl, cap_ctrl: msel_n = 3'b011;    // merq, iorq, m1
            default:            msel_n = 3'b111;
        endcase
        capture = phase_q inside {cap_low, cap_high, cap_ctrl};
    end

    ////////////////////////////////////////////////////////////
    // cycle decode
    assign slot_mem      = ~cycle.sltsl_n & ~cycle.merq_n & cycle.iorq_n & cycle.m1_n;
    assign sdc_enable_wr = slot_mem & ~cycle.wr_n & (cycle.addr == SDC_ENABLE);
    assign sdc_sel = slot_mem & sd_enabled & (cycle.addr >= SDC_ENABLE) & (cycle.addr <= SDC_END);
    assign buf_sel = slot_mem & sd_enabled & (cycle.addr >= SDC_SDATA) & (cycle.addr < SDC_ENABLE);
    assign io_wr   = ~cycle.iorq_n & cycle.m1_n & cycle.rd_n & ~cycle.wr_n
                   & (cycle.addr[7:0] == MAPPER_PORT);
    assign datadir = ~(~cycle.rd_n & ~cycle.sltsl_n);  // low drives cd toward the host

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_type <= konami;
        end else if (io_wr) begin
            case (cd_in)
                8'h05:   mapper_type <= konami_scc;
                8'h16:   mapper_type <= ascii16;
                8'h08:   mapper_type <= ascii8;
                default: mapper_type <= konami;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read data, the ram path is one stage longer
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sdc_rd_q  <= 1'b0;
            buf_rd_q  <= 1'b0;
            buf_rd_q2 <= 1'b0;
            cd_out    <= IDLE_DATA;
        end else begin
            sdc_rd_q  <= sdc_sel & ~cycle.rd_n;
            buf_rd_q  <= buf_sel & ~cycle.rd_n;
            buf_rd_q2 <= buf_rd_q;
            if (sdc_rd_q)
                cd_out <= reg_rdata;
            else if (buf_rd_q2)
                cd_out <= buf_rdata;
            else
                cd_out <= IDLE_DATA;    // nobody claims it
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sdc_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdc_register_file #(
    parameter int BUF_ADDR_BITS = 9
) (
    input  wire                             clk108_w,
    input  wire                             ram_enabled_w,
    input  wire cart_bus_pkg::bus_cycle_t   cycle,
    input  wire cart_bus_pkg::data_t        cd_in,
    input  wire                             sdc_enable_wr,
    input  wire                             sdc_sel,
    input  wire sdc_pkg::card_stat_t        stat,
    input  wire sdc_pkg::card_info_t        info,
    output logic                            sd_enabled,
    output sdc_pkg::card_req_t              req,
    output cart_bus_pkg::data_t             reg_rdata
);
    import cart_bus_pkg::*;
    import sdc_pkg::*;

    // register window spans half the sector area
    localparam int OFS_BITS = BUF_ADDR_BITS - 1;

    logic [OFS_BITS-1:0] ofs;
    logic                host_wr;
    logic                host_rd;
    logic                rstart_q;
    logic                wstart_q;
    logic                init_q;
    sector_t             sector_q;

    function automatic logic [OFS_BITS-1:0] ofs_of(input logic [15:0] a);
        return a[OFS_BITS-1:0];
    endfunction

    assign ofs     = cycle.addr[OFS_BITS-1:0];
    assign host_wr = sdc_sel & ~cycle.wr_n;
    assign host_rd = sdc_sel & ~cycle.rd_n;

    ////////////////////////////////////////////////////////////
    // host writes
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_enabled <= 1'b0;
            rstart_q   <= 1'b0;
            wstart_q   <= 1'b0;
            init_q     <= 1'b0;
            sector_q   <= '0;
        end else begin
            if (sdc_enable_wr)
                sd_enabled <= cd_in[0];
            if (stat.done) begin    // reader finished, drop the request
                rstart_q <= 1'b0;
                wstart_q <= 1'b0;
            end
            if (host_wr) begin
                case (ofs)
                    ofs_of(SDC_CMD): begin
                        rstart_q <= rstart_q | cd_in[0];
                        wstart_q <= wstart_q | cd_in[1];
                        init_q   <= init_q | cd_in[7];
                    end
                    ofs_of(SDC_SADDR):         sector_q[7:0]   <= cd_in;
                    ofs_of(SDC_SADDR + 16'd1): sector_q[15:8]  <= cd_in;
                    ofs_of(SDC_SADDR + 16'd2): sector_q[23:16] <= cd_in;
                    ofs_of(SDC_SADDR + 16'd3): sector_q[31:24] <= cd_in;
                    default: ;
                endcase
            end
        end
    end

    assign req = '{rstart: rstart_q, wstart: wstart_q, init: init_q, sector: sector_q};

    ////////////////////////////////////////////////////////////
    // host reads
    always_ff @(posedge clk108_w) begin
        if (host_rd) begin
            case (ofs)
                ofs_of(SDC_ENABLE):         reg_rdata <= {7'd0, sd_enabled};
                ofs_of(SDC_STATUS):
                    reg_rdata <= {stat.busy, 5'd0, stat.timeout_error, stat.crc_error};
                ofs_of(SDC_C_SIZE):         reg_rdata <= info.c_size[7:0];
                ofs_of(SDC_C_SIZE + 16'd1): reg_rdata <= info.c_size[15:8];
                ofs_of(SDC_C_SIZE + 16'd2): reg_rdata <= {2'd0, info.c_size[21:16]};
                ofs_of(SDC_CTYPE):          reg_rdata <= {6'd0, info.card_type};
                ofs_of(SDC_MID):            reg_rdata <= info.mid;
                ofs_of(SDC_PSN):            reg_rdata <= info.psn[7:0];
                ofs_of(SDC_PSN + 16'd1):    reg_rdata <= info.psn[15:8];
                ofs_of(SDC_PSN + 16'd2):    reg_rdata <= info.psn[23:16];
                ofs_of(SDC_PSN + 16'd3):    reg_rdata <= info.psn[31:24];
                default:                    reg_rdata <= IDLE_DATA;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sector_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sector_buffer #(
    parameter int BUF_ADDR_BITS = 9
) (
    input  wire                         clk108_w,
    input  wire                         host_we,
    input  wire                         host_re,
    input  wire  [BUF_ADDR_BITS-1:0]    host_addr,
    input  wire cart_bus_pkg::data_t    host_wdata,
    output cart_bus_pkg::data_t         host_rdata,
    input  wire                         card_we,
    input  wire                         card_re,
    input  wire  [BUF_ADDR_BITS-1:0]    card_addr,
    input  wire cart_bus_pkg::data_t    card_wdata,
    output cart_bus_pkg::data_t         card_rdata
);
    import cart_bus_pkg::*;

    data_t mem [2**BUF_ADDR_BITS];  // one sd sector

    // host port
    always @(posedge clk108_w) begin
        if (host_we)
            mem[host_addr] <= host_wdata;
        if (host_re)
            host_rdata <= mem[host_addr];
    end

    // card reader port
    always @(posedge clk108_w) begin
        if (card_we)
            mem[card_addr] <= card_wdata;
        if (card_re)
            card_rdata <= mem[card_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/sd_cart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_cart_top #(
    parameter int BUF_ADDR_BITS = 9
) (
    input  wire                         clk108_w,
    input  wire                         ram_enabled_w,
    input  wire  [7:0]                  mp,
    input  wire                         rd_n,
    input  wire                         wr_n,
    input  wire                         sltsl_n,
    input  wire cart_bus_pkg::data_t    cd_in,
    output cart_bus_pkg::msel_t         msel_n,
    output cart_bus_pkg::data_t         cd_out,
    output logic                        datadir,
    output sdc_pkg::mapper_type_t       mapper_type,
    output sdc_pkg::card_req_t          card_req,
    input  wire sdc_pkg::card_stat_t    card_stat,
    input  wire sdc_pkg::card_info_t    card_info,
    input  wire                         outen,
    input  wire  [BUF_ADDR_BITS-1:0]    outaddr,
    input  wire cart_bus_pkg::data_t    outbyte,
    output cart_bus_pkg::data_t         inbyte
);
    import cart_bus_pkg::*;

    bus_cycle_t cycle;
    logic       capture;
    logic       sdc_enable_wr;
    logic       sdc_sel;
    logic       buf_sel;
    logic       sd_enabled;
    data_t      reg_rdata;
    data_t      buf_rdata;

    ////////////////////////////////////////////////////////////
    // host side
    mux_bus_sampler mux_bus_sampler_i (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w), .mp(mp),
        .rd_n(rd_n), .wr_n(wr_n), .sltsl_n(sltsl_n),
        .msel_n(msel_n), .capture(capture), .cycle(cycle)
    );

    cart_bus_control cart_bus_control_i (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w), .cycle(cycle),
        .cd_in(cd_in), .sd_enabled(sd_enabled), .reg_rdata(reg_rdata),
        .buf_rdata(buf_rdata), .msel_n(msel_n), .capture(capture),
        .sdc_enable_wr(sdc_enable_wr), .sdc_sel(sdc_sel), .buf_sel(buf_sel),
        .mapper_type(mapper_type), .cd_out(cd_out), .datadir(datadir)
    );

    ////////////////////////////////////////////////////////////
    // sd controller and transfer area
    sdc_register_file #(.BUF_ADDR_BITS(BUF_ADDR_BITS)) sdc_register_file_i (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w), .cycle(cycle),
        .cd_in(cd_in), .sdc_enable_wr(sdc_enable_wr), .sdc_sel(sdc_sel),
        .stat(card_stat), .info(card_info), .sd_enabled(sd_enabled),
        .req(card_req), .reg_rdata(reg_rdata)
    );

    // reader fills the buffer on a read request, drains it on a write request
    sector_buffer #(.BUF_ADDR_BITS(BUF_ADDR_BITS)) sector_buffer_i (
        .clk108_w(clk108_w),
        .host_we(buf_sel & ~cycle.wr_n),
        .host_re(buf_sel & ~cycle.rd_n),
        .host_addr(cycle.addr[BUF_ADDR_BITS-1:0]),
        .host_wdata(cd_in),
        .host_rdata(buf_rdata),
        .card_we(card_req.rstart & outen),
        .card_re(card_req.wstart & outen),
        .card_addr(outaddr),
        .card_wdata(outbyte),
        .card_rdata(inbyte)
    );

endmodule

`default_nettype wire

// ==== verif/sd_cart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_cart_tb;
    import cart_bus_pkg::*;
    import sdc_pkg::*;

    localparam int BUF_ADDR_BITS = 9;
    localparam int STROBE_CYCLES = 24;  // three dot frames
    localparam int FRAME_CYCLES  = 8;
    localparam int CLEAR_LIMIT   = 4;

    logic                     clk108_w = 1'b0;
    logic                     ram_enabled_w;
    logic [7:0]               mp = 8'hff;
    logic                     rd_n;
    logic                     wr_n;
    logic                     sltsl_n;
    data_t                    cd_in;
    msel_t                    msel_n;
    data_t                    cd_out;
    logic                     datadir;
    mapper_type_t             mapper_type;
    card_req_t                card_req;
    card_stat_t               card_stat;
    card_info_t               card_info;
    logic                     outen;
    logic [BUF_ADDR_BITS-1:0] outaddr;
    data_t                    outbyte;
    data_t                    inbyte;

    // what the host puts on the mux pins
    addr_t       bus_addr;
    logic        bus_merq_n;
    logic        bus_iorq_n;
    logic        bus_m1_n;

    logic [31:0] lfsr_q;
    string       test_name;
    int          test_count;
    int          check_count;
    int          error_count;
    int          test_errors;

    sd_cart_top #(.BUF_ADDR_BITS(BUF_ADDR_BITS)) sd_cart_top_i (
        .clk108_w(clk108_w), .ram_enabled_w(ram_enabled_w), .mp(mp),
        .rd_n(rd_n), .wr_n(wr_n), .sltsl_n(sltsl_n), .cd_in(cd_in),
        .msel_n(msel_n), .cd_out(cd_out), .datadir(datadir),
        .mapper_type(mapper_type), .card_req(card_req), .card_stat(card_stat),
        .card_info(card_info), .outen(outen), .outaddr(outaddr),
        .outbyte(outbyte), .inbyte(inbyte)
    );

    always #2 clk108_w = ~clk108_w;    // 4 ns period

    ////////////////////////////////////////////////////////////
    // host bus model drives the group that msel_n picks
    always @(posedge clk108_w) begin
        case (msel_n)
            3'b110:  mp <= bus_addr[7:0];
            3'b101:  mp <= bus_addr[15:8];
            3'b011:  mp <= {bus_m1_n, 5'b11111, bus_iorq_n, bus_merq_n};
            default: mp <= 8'hff;
        endcase
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_q[31]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_count++;
    endtask

    task automatic end_test();
        if (test_errors == 0)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, test_errors);
    endtask

    task automatic note_failure();
        error_count++;
        test_errors++;
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected)
        else begin
            $display("error %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
            note_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // host cycles hold the strobes for three frames
    task automatic host_write(input addr_t addr, input data_t data, input logic io);
        @(posedge clk108_w);
        bus_addr   <= addr;
        bus_merq_n <= io;
        bus_iorq_n <= ~io;
        bus_m1_n   <= 1'b1;
        cd_in      <= data;
        repeat (2) @(posedge clk108_w);
        wr_n    <= 1'b0;
        sltsl_n <= io;  // slot select only on memory cycles
        repeat (STROBE_CYCLES) @(posedge clk108_w);
        wr_n    <= 1'b1;
        sltsl_n <= 1'b1;
        repeat (FRAME_CYCLES) @(posedge clk108_w);
    endtask

    task automatic host_read(input addr_t addr, output data_t data);
        int waited;
        data = IDLE_DATA;
        @(posedge clk108_w);
        bus_addr   <= addr;
        bus_merq_n <= 1'b0;
        bus_iorq_n <= 1'b1;
        bus_m1_n   <= 1'b1;
        repeat (2) @(posedge clk108_w);
        rd_n    <= 1'b0;
        sltsl_n <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk108_w);
            waited++;
        end while (datadir !== 1'b0 && waited < STROBE_CYCLES - FRAME_CYCLES);
        check_count++;
        assert (datadir === 1'b0)
        else begin
            $display("%s: datadir never went low during a read of %h", test_name, addr);
            note_failure();
        end
        repeat (FRAME_CYCLES) @(posedge clk108_w);   // let the read data settle
        data = cd_out;
        assert (datadir === 1'b0)
        else begin
            $display("%s: read of %h ended before the data was taken", test_name, addr);
            note_failure();
        end
        repeat (STROBE_CYCLES - FRAME_CYCLES - waited) @(posedge clk108_w);
        rd_n    <= 1'b1;
        sltsl_n <= 1'b1;
        repeat (FRAME_CYCLES) @(posedge clk108_w);
        check_count++;
        assert (datadir === 1'b1)
        else begin
            $display("%s: datadir stayed low after a read of %h", test_name, addr);
            note_failure();
        end
    endtask

    task automatic pulse_done();
        @(posedge clk108_w);
        card_stat.done <= 1'b1;
        @(posedge clk108_w);
        card_stat.done <= 1'b0;
    endtask

    task automatic wait_request_clear(input string what);
        int waited;
        waited = 0;
        while ((card_req.rstart | card_req.wstart) !== 1'b0 && waited < CLEAR_LIMIT) begin
            @(posedge clk108_w);
            waited++;
        end
        check_count++;
        assert ((card_req.rstart | card_req.wstart) === 1'b0)
        else begin
            $display("%s: %s stayed high after done", test_name, what);
            note_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_reset_state();
        begin_test("reset_state");
        repeat (10) @(posedge clk108_w);
        check_value("msel_n", 64'(3'b111), 64'(msel_n));
        check_value("datadir", 64'd1, 64'(datadir));
        check_value("card_req", 64'd0, 64'(card_req));
        check_value("mapper_type", 64'(konami), 64'(mapper_type));
        check_value("cd_out", 64'hff, 64'(cd_out));
        ram_enabled_w <= 1'b1;
        end_test();
    endtask

    task automatic test_dot_sequence();
        msel_t prev;
        msel_t expected;
        int    waited;
        begin_test("dot_sequence");
        prev = msel_n;
        @(posedge clk108_w);
        waited = 1;
        while (!(prev == 3'b111 && msel_n == 3'b110) && waited < 2 * FRAME_CYCLES) begin
            prev = msel_n;
            @(posedge clk108_w);
            waited++;
        end
        check_count++;
        assert (prev == 3'b111 && msel_n == 3'b110)
        else begin
            $display("%s: no frame start found on msel_n", test_name);
            note_failure();
        end
        for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
            case ((i / 2) % 4)
                0:       expected = 3'b110;
                1:       expected = 3'b101;
                2:       expected = 3'b011;
                default: expected = 3'b111;
            endcase
            check_value($sformatf("msel_n cycle %0d", i), 64'(expected), 64'(msel_n));
            @(posedge clk108_w);
        end
        end_test();
    endtask

    task automatic test_sdc_registers();
        data_t       rdata;
        logic [63:0] r;
        data_t       saddr [4];
        card_info_t  info;
        addr_t       info_addr [10];
        data_t       info_byte [10];
        begin_test("sdc_registers");
        host_read(SDC_STATUS, rdata);
        check_value("status before enable", 64'hff, 64'(rdata));
        host_write(SDC_ENABLE, 8'h01, 1'b0);
        host_read(SDC_ENABLE, rdata);
        check_value("enable readback", 64'h01, 64'(rdata));
        for (int i = 0; i < 4; i++) begin
            draw_bits(8, r);
            saddr[i] = r[7:0];
            host_write(SDC_SADDR + addr_t'(i), saddr[i], 1'b0);
        end
        check_value("sector number", 64'({saddr[3], saddr[2], saddr[1], saddr[0]}),
                    64'(card_req.sector));
        draw_bits(64, r);
        info = card_info_t'(r);
        @(posedge clk108_w);
        card_info <= info;
        info_addr = '{SDC_C_SIZE, SDC_C_SIZE + 16'd1, SDC_C_SIZE + 16'd2, SDC_CTYPE,
                      SDC_MID, SDC_PSN, SDC_PSN + 16'd1, SDC_PSN + 16'd2,
                      SDC_PSN + 16'd3, 16'h7e20};
        info_byte = '{info.c_size[7:0], info.c_size[15:8], {2'b00, info.c_size[21:16]},
                      {6'd0, info.card_type}, info.mid, info.psn[7:0], info.psn[15:8],
                      info.psn[23:16], info.psn[31:24], 8'hff};
        for (int i = 0; i < 10; i++) begin
            host_read(info_addr[i], rdata);
            check_value($sformatf("register %h", info_addr[i]), 64'(info_byte[i]),
                        64'(rdata));
        end
        end_test();
    endtask

    task automatic test_command_handshake();
        data_t rdata;
        begin_test("command_handshake");
        @(posedge clk108_w);
        card_stat <= '{busy: 1'b1, done: 1'b0, crc_error: 1'b1, timeout_error: 1'b0};
        host_write(SDC_CMD, 8'h01, 1'b0);
        check_value("rstart after command", 64'd1, 64'(card_req.rstart));
        host_read(SDC_STATUS, rdata);
        check_value("status busy with crc error", 64'h81, 64'(rdata));
        check_value("rstart before done", 64'd1, 64'(card_req.rstart));
        pulse_done();
        wait_request_clear("rstart");
        card_stat <= '0;
        host_write(SDC_CMD, 8'h80, 1'b0);
        check_value("init after command", 64'd1, 64'(card_req.init));
        check_value("start bits with init", 64'd0, 64'({card_req.rstart, card_req.wstart}));
        end_test();
    endtask

    task automatic test_sector_buffer();
        logic [BUF_ADDR_BITS-1:0] host_ofs [4];
        logic [BUF_ADDR_BITS-1:0] card_ofs [4];
        data_t                    bytes [4];
        logic [63:0]              r;
        data_t                    rdata;
        begin_test("sector_buffer");
        host_ofs = '{9'h000, 9'h001, 9'h100, 9'h1ff};
        card_ofs = '{9'h002, 9'h055, 9'h1aa, 9'h1fe};
        for (int i = 0; i < 4; i++) begin
            draw_bits(8, r);
            bytes[i] = r[7:0];
            host_write(SDC_SDATA + addr_t'(host_ofs[i]), bytes[i], 1'b0);
        end
        host_write(SDC_CMD, 8'h02, 1'b0);
        check_value("wstart after command", 64'd1, 64'(card_req.wstart));
        for (int i = 0; i < 4; i++) begin
            @(posedge clk108_w);
            outen   <= 1'b1;
            outaddr <= host_ofs[i];
            repeat (2) @(posedge clk108_w);  // registered ram read
            check_value($sformatf("inbyte at %h", host_ofs[i]), 64'(bytes[i]), 64'(inbyte));
        end
        @(posedge clk108_w);
        outen <= 1'b0;
        pulse_done();
        wait_request_clear("wstart");

        // reader side fills and the host drains
        host_write(SDC_CMD, 8'h01, 1'b0);
        check_value("rstart after command", 64'd1, 64'(card_req.rstart));
        for (int i = 0; i < 4; i++) begin
            draw_bits(8, r);
            bytes[i] = r[7:0];
            @(posedge clk108_w);
            outen   <= 1'b1;
            outaddr <= card_ofs[i];
            outbyte <= bytes[i];
        end
        @(posedge clk108_w);
        outen <= 1'b0;
        pulse_done();
        wait_request_clear("rstart");
        for (int i = 0; i < 4; i++) begin
            host_read(SDC_SDATA + addr_t'(card_ofs[i]), rdata);
            check_value($sformatf("host read at %h", card_ofs[i]), 64'(bytes[i]), 64'(rdata));
        end
        end_test();
    endtask

    task automatic test_mapper_type();
        data_t        codes [4];
        mapper_type_t expected [4];
        logic [63:0]  r;
        begin_test("mapper_type");
        codes    = '{8'h05, 8'h16, 8'h08, 8'h3c};
        expected = '{konami_scc, ascii16, ascii8, konami};
        for (int i = 0; i < 4; i++) begin
            draw_bits(8, r);    // upper address byte is don't care on io
            host_write({r[7:0], MAPPER_PORT}, codes[i], 1'b1);
            check_value($sformatf("mapper after %h", codes[i]),
                        64'(expected[i]), 64'(mapper_type));
        end
        end_test();
    endtask

    initial begin
        ram_enabled_w = 1'b0;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        sltsl_n       = 1'b1;
        cd_in         = '0;
        card_stat     = '0;
        card_info     = '0;
        outen         = 1'b0;
        outaddr       = '0;
        outbyte       = '0;
        bus_addr      = '0;
        bus_merq_n    = 1'b1;
        bus_iorq_n    = 1'b1;
        bus_m1_n      = 1'b1;
        lfsr_q        = 32'h3fb56fdc;
        test_count    = 0;
        check_count   = 0;
        error_count   = 0;

        test_reset_state();
        test_dot_sequence();
        test_sdc_registers();
        test_command_handshake();
        test_sector_buffer();
        test_mapper_type();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/cart_bus_pkg.sv
hdl/sdc_pkg.sv
hdl/mux_bus_sampler.sv
hdl/cart_bus_control.sv
hdl/sdc_register_file.sv
hdl/sector_buffer.sv
hdl/sd_cart_top.sv
verif/sd_cart_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sd cartridge testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module sd_cart_tb -o sd_cart_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sd_cart_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
